/* verilog/sum_kernel_pkg.sv */
//////////////////////////////
// Integer sums wrap modulo 2**data_bits. Two units need one unit id bit.
//////////////////////////////

package sum_kernel_pkg;

	//////////////////////////////
	// Widths and sizes
	//////////////////////////////

	localparam int vertex_id_bits   = 16;
	localparam int degree_bits      = 12;
	localparam int data_bits        = 32;
	localparam int num_units        = 2;
	localparam int unit_id_bits     = 1;
	localparam int write_fifo_depth = 8;
	localparam int resp_count_bits  = 16;

	//////////////////////////////
	// Stream payloads
	//////////////////////////////

	// Vertex job, degree is the in-edge count
	typedef struct packed {
		logic [vertex_id_bits-1:0] vertex_id;
		logic [degree_bits-1:0]    degree;
	} vertex_job_t;

	typedef struct packed {
		logic [data_bits-1:0] data;
	} edge_data_t;

	// One record per finished vertex
	typedef struct packed {
		logic [vertex_id_bits-1:0] vertex_id;
		logic [unit_id_bits-1:0]   unit_id;
		logic [data_bits-1:0]      sum;
	} write_record_t;

	// Response tag, unit id selects the destination unit
	typedef struct packed {
		logic [unit_id_bits-1:0]   unit_id;
		logic [vertex_id_bits-1:0] vertex_id;
	} write_resp_t;

endpackage

/* verilog/sync_fifo.sv */
//////////////////////////////
// Caller must not push when full or pop when empty
//////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 8
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	output logic     full,
	output logic     almost_full,
	input  logic     pop,
	output payload_t data_out,
	output logic     empty
);

	localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_bits = $clog2(depth + 1);

	payload_t              mem [depth];
	logic [ptr_bits-1:0]   wr_ptr;
	logic [ptr_bits-1:0]   rd_ptr;
	logic [count_bits-1:0] count;

	// Wrap also works for depths that are not a power of two
	function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
		if (ptr == ptr_bits'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign data_out    = mem[rd_ptr];
	assign empty       = (count == '0);
	assign full        = (count == count_bits'(depth));
	assign almost_full = (count >= count_bits'(depth - 1));

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("sync_fifo: push while full");
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("sync_fifo: pop while empty");

endmodule

/* verilog/vertex_sum_kernel.sv */
//////////////////////////////
// Disabled unit freezes its handshakes, responses are still counted
//////////////////////////////

`timescale 1ns/1ps

module vertex_sum_kernel #(
	parameter logic [sum_kernel_pkg::unit_id_bits-1:0] unit_id = '0
) (
	input  logic                                       clock,
	input  logic                                       rstn,
	input  logic                                       enable,
	input  logic                                       job_valid,
	output logic                                       job_ready,
	input  sum_kernel_pkg::vertex_job_t                job,
	input  logic                                       edge_valid,
	output logic                                       edge_ready,
	input  sum_kernel_pkg::edge_data_t                 edge_data,
	output logic                                       bus_request,
	input  logic                                       bus_grant,
	output sum_kernel_pkg::write_record_t              head,
	input  logic                                       resp_valid,
	output logic [sum_kernel_pkg::resp_count_bits-1:0] resp_count
);

	import sum_kernel_pkg::*;

	typedef enum logic {
		st_idle,
		st_accum
	} state_t;

	state_t                    state;
	logic [degree_bits-1:0]    remaining;
	logic [data_bits-1:0]      running_sum;
	logic [vertex_id_bits-1:0] latched_vertex;
	logic                      job_fire;
	logic                      edge_fire;
	logic                      push;
	write_record_t             record;
	logic                      queue_full;
	logic                      queue_almost_full;
	logic                      queue_empty;

	//////////////////////////////
	// Handshakes
	//////////////////////////////

	assign job_ready = enable && (state == st_idle);
	assign job_fire  = job_valid && job_ready;

	// Stop taking edges before the queue can overflow
	assign edge_ready = enable && (state == st_accum) && (remaining != '0)
		&& !queue_almost_full;
	assign edge_fire  = edge_valid && edge_ready;

	// Count at zero means the sum is complete, zero-degree jobs land here at once
	assign push = enable && (state == st_accum) && (remaining == '0) && !queue_full;

	//////////////////////////////
	// Job control
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= st_idle;
			remaining <= '0;
		end else begin
			if (job_fire) begin
				state     <= st_accum;
				remaining <= job.degree;
			end else if (edge_fire) begin
				remaining <= remaining - 1'b1;
			end else if (push) begin
				state <= st_idle;
			end
		end
	end

	// Sum and vertex id
	always_ff @(posedge clock) begin
		if (job_fire) begin
			latched_vertex <= job.vertex_id;
			running_sum    <= '0;
		end else if (edge_fire) begin
			running_sum <= running_sum + edge_data.data;
		end
	end

	assign record = '{vertex_id: latched_vertex, unit_id: unit_id, sum: running_sum};

	//////////////////////////////
	// Write queue
	//////////////////////////////

	sync_fifo #(
		.payload_t(write_record_t),
		.depth    (write_fifo_depth)
	) u_write_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push),
		.data_in    (record),
		.full       (queue_full),
		.almost_full(queue_almost_full),
		.pop        (bus_grant),
		.data_out   (head),
		.empty      (queue_empty)
	);

	assign bus_request = enable && !queue_empty;

	// Responses arrive already routed by unit id
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_count <= '0;
		end else if (resp_valid) begin
			resp_count <= resp_count + 1'b1;
		end
	end

	// Arbiter must only grant a unit that is asking
	assert property (@(posedge clock) disable iff (!rstn) bus_grant |-> bus_request)
		else $error("vertex_sum_kernel: grant without request");

endmodule

/* verilog/write_bus_arbiter.sv */
//////////////////////////////
// write_valid is combinational from requests and a grant needs write_ready
//////////////////////////////

`timescale 1ns/1ps

module write_bus_arbiter (
	input  logic                                                     clock,
	input  logic                                                     rstn,
	input  logic [sum_kernel_pkg::num_units-1:0]                     request,
	input  sum_kernel_pkg::write_record_t [sum_kernel_pkg::num_units-1:0] heads,
	output logic [sum_kernel_pkg::num_units-1:0]                     grant,
	output logic                                                     write_valid,
	input  logic                                                     write_ready,
	output sum_kernel_pkg::write_record_t                            write,
	input  logic                                                     resp_valid,
	input  sum_kernel_pkg::write_resp_t                              resp,
	output logic [sum_kernel_pkg::num_units-1:0]                     resp_route
);

	import sum_kernel_pkg::*;

	logic [unit_id_bits-1:0] pointer;
	logic [unit_id_bits-1:0] winner;
	logic [unit_id_bits-1:0] candidate;
	logic                    found;
	logic                    handshake;

	// Search from the pointer, first requester wins
	always_comb begin
		found     = 1'b0;
		winner    = pointer;
		candidate = pointer;
		for (int i = 0; i < num_units; i++) begin
			candidate = unit_id_bits'((int'(pointer) + i) % num_units);
			if (!found && request[candidate]) begin
				found  = 1'b1;
				winner = candidate;
			end
		end
	end

	assign write_valid = found;
	assign write       = heads[winner];
	assign handshake   = write_valid && write_ready;
	assign grant       = handshake ? (num_units'(1) << winner) : '0;

	// Move past the unit just served
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer <= '0;
		end else if (handshake) begin
			pointer <= unit_id_bits'((int'(winner) + 1) % num_units);
		end
	end

	//////////////////////////////
	// Response routing
	//////////////////////////////

	assign resp_route = resp_valid ? (num_units'(1) << resp.unit_id) : '0;

	// Pointer must move on when every unit keeps asking
	assert property (@(posedge clock) disable iff (!rstn)
		(handshake && (request == '1))
		|=> (!(handshake && (request == '1)) || (grant != $past(grant))))
		else $error("write_bus_arbiter: same unit granted twice while all units wait");

endmodule

/* verilog/sum_kernel_cluster.sv */
//////////////////////////////
// Unit i sits at index i of every per-unit port
//////////////////////////////

`timescale 1ns/1ps

module sum_kernel_cluster (
	input  logic                                             clock,
	input  logic                                             rstn,
	input  logic [sum_kernel_pkg::num_units-1:0]             enable,
	input  logic [sum_kernel_pkg::num_units-1:0]             job_valid,
	output logic [sum_kernel_pkg::num_units-1:0]             job_ready,
	input  sum_kernel_pkg::vertex_job_t [sum_kernel_pkg::num_units-1:0] job,
	input  logic [sum_kernel_pkg::num_units-1:0]             edge_valid,
	output logic [sum_kernel_pkg::num_units-1:0]             edge_ready,
	input  sum_kernel_pkg::edge_data_t [sum_kernel_pkg::num_units-1:0]  edge_data,
	output logic                                             write_valid,
	input  logic                                             write_ready,
	output sum_kernel_pkg::write_record_t                    write,
	input  logic                                             resp_valid,
	input  sum_kernel_pkg::write_resp_t                      resp,
	output logic [sum_kernel_pkg::num_units-1:0][sum_kernel_pkg::resp_count_bits-1:0] resp_count
);

	import sum_kernel_pkg::*;

	logic [num_units-1:0]          bus_request;
	logic [num_units-1:0]          bus_grant;
	logic [num_units-1:0]          resp_route;
	write_record_t [num_units-1:0] heads;

	// Unit id equals the array index
	for (genvar i = 0; i < num_units; i++) begin : gen_unit
		vertex_sum_kernel #(
			.unit_id(unit_id_bits'(i))
		) u_kernel (
			.clock      (clock),
			.rstn       (rstn),
			.enable     (enable[i]),
			.job_valid  (job_valid[i]),
			.job_ready  (job_ready[i]),
			.job        (job[i]),
			.edge_valid (edge_valid[i]),
			.edge_ready (edge_ready[i]),
			.edge_data  (edge_data[i]),
			.bus_request(bus_request[i]),
			.bus_grant  (bus_grant[i]),
			.head       (heads[i]),
			.resp_valid (resp_route[i]),
			.resp_count (resp_count[i])
		);
	end

	write_bus_arbiter u_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.request    (bus_request),
		.heads      (heads),
		.grant      (bus_grant),
		.write_valid(write_valid),
		.write_ready(write_ready),
		.write      (write),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_route (resp_route)
	);

endmodule

/* bench/tb_sum_kernel_model.svh */
//////////////////////////////
// Included inside the testbench module after the package import
//////////////////////////////

`ifndef TB_SUM_KERNEL_MODEL_SVH
`define TB_SUM_KERNEL_MODEL_SVH

// Expected records per unit, in job order
write_record_t expected_q [num_units][$];

// Record a unit must write for one vertex, sum wraps at 2**32
function automatic write_record_t reference_record(
	input int                   unit_index,
	input int                   vertex,
	input logic [data_bits-1:0] words [16],
	input int                   degree
);
	write_record_t        rec;
	logic [data_bits-1:0] total;
	total = '0;
	for (int i = 0; i < degree; i++) begin
		total = total + words[i];
	end
	rec.vertex_id = vertex_id_bits'(vertex);
	rec.unit_id   = unit_id_bits'(unit_index);
	rec.sum       = total;
	return rec;
endfunction

task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("=== FAIL ===");
	$fatal(1);
endtask

task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
	if (actual !== expected) begin
		abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
	end
endtask

`endif

/* bench/tb_sum_kernel_cluster.sv */
//////////////////////////////
// Self-checking testbench with a randomly delayed write responder
//////////////////////////////

`timescale 1ns/1ps

module tb_sum_kernel_cluster;

	import sum_kernel_pkg::*;

	logic                                      clock;
	logic                                      rstn;
	logic [num_units-1:0]                      enable;
	logic [num_units-1:0]                      job_valid;
	logic [num_units-1:0]                      job_ready;
	vertex_job_t [num_units-1:0]               job;
	logic [num_units-1:0]                      edge_valid;
	logic [num_units-1:0]                      edge_ready;
	edge_data_t [num_units-1:0]                edge_data;
	logic                                      write_valid;
	logic                                      write_ready;
	write_record_t                             write;
	logic                                      resp_valid;
	write_resp_t                               resp;
	logic [num_units-1:0][resp_count_bits-1:0] resp_count;

	integer               seed = 32'h0062bf17;
	int                   total_edges = 0;
	int                   cycles = 0;
	int                   alternations = 0;
	int                   resp_sent [num_units] = '{0, 0};
	int                   vertex_owner [int];
	logic                 stall_phase = 1'b0;
	logic                 unit1_paused = 1'b0;
	logic [num_units-1:0] saw_backpressure = '0;
	logic                 last_unit = 1'b1;
	write_resp_t          pending [$];

	`include "tb_sum_kernel_model.svh"

	sum_kernel_cluster DUT (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic run_job(input int u, input int vertex, input int degree);
		logic [data_bits-1:0] words [16];
		for (int i = 0; i < 16; i++) begin
			words[i] = $random(seed);
		end
		expected_q[u].push_back(reference_record(u, vertex, words, degree));
		vertex_owner[vertex] = u;
		total_edges = total_edges + degree;
		@(negedge clock);
		job[u].vertex_id = vertex_id_bits'(vertex);
		job[u].degree    = degree_bits'(degree);
		job_valid[u]     = 1'b1;
		do @(posedge clock); while (!job_ready[u]);
		@(negedge clock);
		job_valid[u] = 1'b0;
		for (int i = 0; i < degree; i++) begin
			edge_data[u].data = words[i];
			edge_valid[u]     = 1'b1;
			do @(posedge clock); while (!edge_ready[u]);
			@(negedge clock);
			edge_valid[u] = 1'b0;
		end
	endtask

	// Degrees drawn from lo to hi
	task automatic run_jobs(input int u, input int count, input int base, input int lo,
			input int hi);
		int degree;
		for (int k = 0; k < count; k++) begin
			degree = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
			run_job(u, base + k, degree);
		end
	endtask

	// One response per accepted write
	initial begin
		resp_valid = 1'b0;
		resp       = '0;
		forever begin
			@(negedge clock);
			resp_valid = 1'b0;
			if (rstn && pending.size() != 0 && ($random(seed) & 3) == 0) begin
				resp       = pending.pop_front();
				resp_valid = 1'b1;
				resp_sent[resp.unit_id]++;
			end
		end
	end

	//////////////////////////////
	// Write port checks
	//////////////////////////////

	always @(posedge clock) begin : compare
		write_record_t expected;
		write_resp_t   tag;
		if (write_valid && write_ready) begin
			if (!vertex_owner.exists(int'(write.vertex_id))) begin
				abort_run("A write record carries a vertex id that no job issued");
			end else begin
				// Owner is the unit that was handed the job
				check_value("write.unit_id", write.unit_id,
					vertex_owner[int'(write.vertex_id)]);
				if (expected_q[write.unit_id].size() == 0) begin
					abort_run("A write record arrived with no job left for its unit");
				end else if (unit1_paused && write.unit_id == 1'b1) begin
					abort_run("Unit 1 wrote a record while disabled");
				end else begin
					expected = expected_q[write.unit_id].pop_front();
					check_value("write.vertex_id", write.vertex_id, expected.vertex_id);
					check_value("write.sum", write.sum, expected.sum);
					// With both units waiting the other unit must win
					if (DUT.bus_request == 2'b11) begin
						check_value("write.unit_id", write.unit_id, !last_unit);
						alternations++;
					end
					last_unit     = write.unit_id;
					tag.unit_id   = write.unit_id;
					tag.vertex_id = write.vertex_id;
					pending.push_back(tag);
				end
			end
		end
		if (stall_phase) begin
			saw_backpressure = saw_backpressure | (edge_valid & ~edge_ready);
		end
	end

	// Limit grows with the edges handed out so far
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > total_edges * 8 + 500) begin
			abort_run("Timeout, the cluster stopped making progress");
		end
	end

	initial begin
		rstn        = 1'b0;
		enable      = '1;
		job_valid   = '0;
		job         = '0;
		edge_valid  = '0;
		edge_data   = '0;
		write_ready = 1'b1;
		repeat (2) @(negedge clock);
		rstn = 1'b1;

		fork
			run_jobs(0, 20, 16'h0000, 0, 15);
			run_jobs(1, 20, 16'h1000, 0, 15);
		join
		fork
			run_job(0, 16'h0100, 0);
			run_job(1, 16'h1100, 0);
		join

		// Write port held off while both units fill their queues
		write_ready = 1'b0;
		stall_phase = 1'b1;
		fork
			run_jobs(0, 12, 16'h0200, 1, 2);
			run_jobs(1, 12, 16'h1200, 1, 2);
			begin
				repeat (40) @(negedge clock);
				write_ready = 1'b1;
				stall_phase = 1'b0;
			end
		join
		if (saw_backpressure != 2'b11) begin
			abort_run("edge_ready did not drop on both units during the write stall");
		end

		// Unit 1 paused after four edges of a long job
		fork
			run_jobs(0, 6, 16'h0300, 0, 15);
			run_jobs(1, 3, 16'h1300, 15, 15);
			begin
				repeat (4) begin
					do @(posedge clock); while (!(edge_valid[1] && edge_ready[1]));
				end
				@(negedge clock);
				enable[1]    = 1'b0;
				unit1_paused = 1'b1;
				repeat (30) @(negedge clock);
				enable[1]    = 1'b1;
				unit1_paused = 1'b0;
			end
		join

		while (expected_q[0].size() + expected_q[1].size() + pending.size() != 0) begin
			@(negedge clock);
		end
		repeat (2) @(negedge clock);
		for (int u = 0; u < num_units; u++) begin
			check_value($sformatf("resp_count[%0d]", u), resp_count[u], resp_sent[u]);
		end
		if (alternations == 0) begin
			abort_run("Round-robin order was never exercised with both units waiting");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

/* flist.f */
+incdir+bench
verilog/sum_kernel_pkg.sv
verilog/sync_fifo.sv
verilog/vertex_sum_kernel.sv
verilog/write_bus_arbiter.sv
verilog/sum_kernel_cluster.sv
bench/tb_sum_kernel_cluster.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_sum_kernel_cluster -Mdir "$build_dir" -o sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$build_dir/sim" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "=== FAIL ===" "$log"; then
	echo "Simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
echo "Simulation passed"
exit 0
